// ==== bench/debug_checker.sv ====
`timescale 1ns/1ps

module debug_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           i_rx_valid,
    input  logic [dbg_pkg::BYTE_BITS-1:0]  i_rx_data,
    input  logic                           i_rx_ready,
    input  logic                           i_tx_valid,
    input  logic [dbg_pkg::BYTE_BITS-1:0]  i_tx_data,
    input  logic                           i_tx_ready
);
    import dbg_pkg::*;

    logic [31:0] m_imem [IMEM_WORDS];
    logic [31:0] m_regs [NUM_REGS];
    logic [31:0] m_dmem [DMEM_WORDS];
    logic [31:0] m_cnt;
    int          m_pc;
    bit          m_halted;

    logic [7:0]  exp_q [$];
    logic [7:0]  exp_byte;
    logic [31:0] load_word;
    bit          in_load;
    bit          first_word;
    int          load_bytes;
    int          load_addr;
    int          out_pos;
    int          pending = 0;
    int          bytes_expected = 0;

    string       cur_test = "none";
    int          test_errs = 0;
    int          err_total = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    // Reference model, one instruction per call
    function automatic void exec_one();
        instr_u      ins;
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] imm_v;
        logic [31:0] addr;
        if (m_halted) begin
            return;
        end
        ins   = m_imem[m_pc];
        rs_v  = m_regs[ins.i.rs[2:0]];
        rt_v  = m_regs[ins.i.rt[2:0]];
        imm_v = {{16{ins.i.imm[15]}}, ins.i.imm};
        addr  = rs_v + imm_v;
        m_cnt = m_cnt + 1;
        if (ins.i.opcode == OP_HALT) begin
            m_halted = 1'b1;  // PC stays put
            return;
        end
        if ((ins.r.opcode == OP_RTYPE) && (ins.r.funct == FN_ADD)) begin
            m_regs[ins.r.rd[2:0]] = rs_v + rt_v;
        end else if (ins.i.opcode == OP_ADDI) begin
            m_regs[ins.i.rt[2:0]] = addr;
        end else if (ins.i.opcode == OP_SW) begin
            m_dmem[addr[2:0]] = rt_v;
        end
        m_regs[0] = '0;  // r0 reads zero
        m_pc = (m_pc + 1) % IMEM_WORDS;
    endfunction

    task automatic clear_model();
        m_pc     = 0;
        m_cnt    = '0;
        m_halted = 1'b0;
        for (int k = 0; k < NUM_REGS; k++) begin
            m_regs[k] = '0;
        end
        for (int k = 0; k < DMEM_WORDS; k++) begin
            m_dmem[k] = '0;
        end
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int k = 3; k >= 0; k--) begin
            exp_q.push_back(w[k*8 +: 8]);  // MSB first
        end
    endtask

    task automatic push_dump();
        push_word(32'(m_pc));
        push_word(m_cnt);
        for (int k = 0; k < NUM_REGS; k++) begin
            push_word(m_regs[k]);
        end
        for (int k = 0; k < DMEM_WORDS; k++) begin
            push_word(m_dmem[k]);
        end
        bytes_expected += DUMP_WORDS * 4;
    endtask

    // Parses the command stream the same way the host would
    task automatic take_byte(input logic [7:0] b);
        if (!in_load) begin
            if (b == CMD_LOAD) begin
                in_load    = 1'b1;
                first_word = 1'b1;
                load_bytes = 0;
                load_addr  = 0;
            end else if (b == CMD_RUN) begin
                repeat (4 * IMEM_WORDS) exec_one();
                push_dump();
            end else if (b == CMD_STEP) begin
                exec_one();
                push_dump();
            end
        end else begin
            load_word  = {load_word[23:0], b};
            load_bytes = load_bytes + 1;
            if (load_bytes == 4) begin
                load_bytes = 0;
                if (first_word) begin
                    clear_model();
                    first_word = 1'b0;
                end
                if (load_word == LOAD_END) begin
                    in_load = 1'b0;
                end else begin
                    m_imem[load_addr] = load_word;
                    load_addr = (load_addr + 1) % IMEM_WORDS;
                end
            end
        end
    endtask

    task automatic note_error();
        test_errs++;
        err_total++;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (exp_q.size() != 0) begin
            $display("Test %s ended with %0d dump bytes never sent", cur_test, exp_q.size());
            note_error();
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("PASS: %s", cur_test);
        end else begin
            fail_cnt++;
            $display("FAIL: %s with %0d errors", cur_test, test_errs);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if ((exp_q.size() != 0) && i_rx_ready) begin
                $display("Input was ready while %0d dump bytes were pending in %s",
                         exp_q.size(), cur_test);
                note_error();
            end
            if (i_tx_valid && i_tx_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected output byte %02h in %s", i_tx_data, cur_test);
                    note_error();
                end else begin
                    exp_byte = exp_q.pop_front();
                    if (exp_byte !== i_tx_data) begin
                        $display("[ERROR] %s: byte %0d expected %02h actual %02h",
                                 cur_test, out_pos, exp_byte, i_tx_data);
                        note_error();
                    end
                end
                out_pos++;
            end
            if (i_rx_valid && i_rx_ready) begin
                take_byte(i_rx_data);
            end
            pending = exp_q.size();
        end
    end

endmodule

// ==== bench/tb_debug_top.sv ====
`timescale 1ns/1ps

module tb_debug_top;
    import dbg_pkg::*;

    logic       clk = 1'b0;
    logic       reset;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_ready;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_ready = 1'b1;
    bit         stall_en;
    int         bytes_sent = 0;
    int         wd_cycles = 0;
    int         seed = 15569;

    always #10 clk = ~clk;  // 20 ns period

    debug_top debug_top_inst (
        .clk        (clk),
        .reset      (reset),
        .i_rx_valid (rx_valid),
        .i_rx_data  (rx_data),
        .o_rx_ready (rx_ready),
        .o_tx_valid (tx_valid),
        .o_tx_data  (tx_data),
        .i_tx_ready (tx_ready)
    );

    debug_checker debug_checker_inst (
        .clk        (clk),
        .reset      (reset),
        .i_rx_valid (rx_valid),
        .i_rx_data  (rx_data),
        .i_rx_ready (rx_ready),
        .i_tx_valid (tx_valid),
        .i_tx_data  (tx_data),
        .i_tx_ready (tx_ready)
    );

    // Output back-pressure
    always @(negedge clk) begin
        if (stall_en) begin
            tx_ready <= ($urandom % 3 != 0);
        end else begin
            tx_ready <= 1'b1;
        end
    end

    // 200 cycles per byte sent or expected, doubled
    always @(posedge clk) begin
        if (!reset) begin
            wd_cycles++;
            if (wd_cycles > 2 * 200 * (bytes_sent + debug_checker_inst.bytes_expected + 1)) begin
                $display("Watchdog expired after %0d cycles without the dump completing",
                         wd_cycles);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_byte(input logic [7:0] b);
        rx_valid = 1'b1;
        rx_data  = b;
        while (!rx_ready) @(negedge clk);
        @(negedge clk);
        rx_valid = 1'b0;
        bytes_sent++;
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int k = 3; k >= 0; k--) begin
            send_byte(w[k*8 +: 8]);
        end
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        rs  = 5'($urandom % 8);
        rt  = 5'($urandom % 8);
        rd  = 5'($urandom % 8);
        imm = 16'($urandom);
        case ($urandom % 3)
            0:       return {OP_ADDI, rs, rt, imm};
            1:       return {OP_RTYPE, rs, rt, rd, 5'd0, FN_ADD};
            default: return {OP_SW, rs, rt, imm};
        endcase
    endfunction

    function automatic logic [7:0] junk_byte();
        logic [7:0] b;
        b = 8'($urandom);
        while ((b == CMD_LOAD) || (b == CMD_RUN) || (b == CMD_STEP)) begin
            b = 8'($urandom);
        end
        return b;
    endfunction

    task automatic load_program(input int n, input bit write_r0);
        send_byte(CMD_LOAD);
        for (int k = 0; k < n; k++) begin
            if (write_r0 && (k == 0)) begin
                send_word({OP_ADDI, 5'd0, 5'd0, 16'h1234});  // Write to r0
            end else if (write_r0 && (k == 1)) begin
                send_word({OP_SW, 5'd0, 5'd0, 16'd3});  // r0 into d3
            end else begin
                send_word(random_instr());
            end
        end
        send_word({OP_HALT, 26'd0});
        send_word(LOAD_END);
    endtask

    task automatic wait_dump();
        while ((debug_checker_inst.pending != 0) || !rx_ready) @(negedge clk);
    endtask

    initial begin
        void'($urandom(seed));
        reset    = 1'b1;
        rx_valid = 1'b0;
        rx_data  = '0;
        stall_en = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        debug_checker_inst.start_test("run_to_halt");
        load_program(6 + $urandom % 8, 1'b0);
        send_byte(CMD_RUN);
        wait_dump();
        debug_checker_inst.finish_test();

        debug_checker_inst.start_test("single_step");
        load_program(4, 1'b0);
        repeat (6) begin  // Last step lands on a halted core
            send_byte(CMD_STEP);
            wait_dump();
        end
        debug_checker_inst.finish_test();

        debug_checker_inst.start_test("unknown_bytes");
        load_program(8, 1'b0);
        repeat (5) send_byte(junk_byte());
        repeat (40) @(negedge clk);
        send_byte(CMD_RUN);
        wait_dump();
        debug_checker_inst.finish_test();

        debug_checker_inst.start_test("tx_stall");
        stall_en = 1'b1;
        load_program(10, 1'b0);
        send_byte(CMD_RUN);
        wait_dump();
        stall_en = 1'b0;
        debug_checker_inst.finish_test();

        debug_checker_inst.start_test("reload_clears");
        load_program(7, 1'b1);
        send_byte(CMD_RUN);
        wait_dump();
        debug_checker_inst.finish_test();

        $display("Tests passed: %0d, failed: %0d",
                 debug_checker_inst.pass_cnt, debug_checker_inst.fail_cnt);
        if ((debug_checker_inst.fail_cnt == 0) && (debug_checker_inst.err_total == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           i_rx_valid,
    input  logic [dbg_pkg::BYTE_BITS-1:0]  i_rx_data,
    output logic                           o_rx_ready,
    input  logic                           i_accept,
    output dbg_pkg::dbg_cmd_t              o_cmd
);
    import dbg_pkg::*;

    cmd_kind_e            cmd_kind;
    logic                 in_load;
    logic [1:0]           byte_cnt;
    logic [WORD_BITS-1:0] shift_word;
    logic [WORD_BITS-1:0] next_word;
    logic                 take;

    // Hold off while a command pulse is still on its way to the controller
    assign o_rx_ready = i_accept && (cmd_kind == NONE);
    assign take       = i_rx_valid && o_rx_ready;
    assign next_word  = {shift_word[WORD_BITS-BYTE_BITS-1:0], i_rx_data};

    assign o_cmd.kind = cmd_kind;
    assign o_cmd.word = shift_word;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_kind <= NONE;
            in_load  <= 1'b0;
            byte_cnt <= '0;
        end else begin
            cmd_kind <= NONE;  // One-cycle pulse
            if (take) begin
                if (!in_load) begin
                    case (i_rx_data)
                        CMD_LOAD: begin
                            in_load  <= 1'b1;
                            byte_cnt <= '0;
                        end
                        CMD_RUN:  cmd_kind <= RUN;
                        CMD_STEP: cmd_kind <= STEP;
                        default:  cmd_kind <= NONE;  // Unknown bytes dropped
                    endcase
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'(BYTES_PER_WORD - 1)) begin
                        if (next_word == LOAD_END) begin
                            cmd_kind <= LOAD_DONE;
                            in_load  <= 1'b0;
                        end else begin
                            cmd_kind <= LOAD_WORD;
                        end
                    end
                end
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (take && in_load) begin
            shift_word <= next_word;
        end
    end

endmodule

// ==== hw/dbg_pkg.sv ====
package dbg_pkg;

    // Sizes
    localparam int WORD_BITS      = 32;
    localparam int BYTE_BITS      = 8;
    localparam int BYTES_PER_WORD = WORD_BITS / BYTE_BITS;
    localparam int IMEM_WORDS     = 16;
    localparam int NUM_REGS       = 8;
    localparam int DMEM_WORDS     = 8;
    localparam int DUMP_WORDS     = 2 + NUM_REGS + DMEM_WORDS;
    localparam int IMEM_AW        = $clog2(IMEM_WORDS);
    localparam int REG_AW         = $clog2(NUM_REGS);
    localparam int DMEM_AW        = $clog2(DMEM_WORDS);
    localparam int SEL_IDX_BITS   = 3;
    localparam int DUMP_CNT_BITS  = 5;

    // Command bytes, ASCII
    localparam logic [BYTE_BITS-1:0] CMD_LOAD = 8'h6C;  // 'l'
    localparam logic [BYTE_BITS-1:0] CMD_RUN  = 8'h72;  // 'r'
    localparam logic [BYTE_BITS-1:0] CMD_STEP = 8'h73;  // 's'
    localparam logic [WORD_BITS-1:0] LOAD_END = 32'hFFFF_FFFF;

    // Opcodes and funct
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_HALT  = 6'h3F;
    localparam logic [5:0] FN_ADD   = 6'h20;

    // Dump areas
    localparam logic [1:0] AREA_CTRL = 2'd0;
    localparam logic [1:0] AREA_REG  = 2'd1;
    localparam logic [1:0] AREA_MEM  = 2'd2;
    localparam logic [SEL_IDX_BITS-1:0] SEL_PC    = 3'd0;
    localparam logic [SEL_IDX_BITS-1:0] SEL_COUNT = 3'd1;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        NONE,
        RUN,
        STEP,
        LOAD_WORD,
        LOAD_DONE
    } cmd_kind_e;

    typedef struct packed {
        cmd_kind_e              kind;
        logic [WORD_BITS-1:0]   word;
    } dbg_cmd_t;

    typedef struct packed {
        logic [1:0]              area;
        logic [SEL_IDX_BITS-1:0] index;
    } dump_sel_t;

endpackage

// ==== hw/debug_ctrl.sv ====
`timescale 1ns/1ps

module debug_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  dbg_pkg::dbg_cmd_t               i_cmd,
    output logic                            o_accept,
    output logic                            o_step_en,
    output logic                            o_clear,
    output logic                            o_imem_we,
    output logic [dbg_pkg::IMEM_AW-1:0]     o_imem_addr,
    output logic [dbg_pkg::WORD_BITS-1:0]   o_imem_data,
    input  logic                            i_halted,
    output dbg_pkg::dump_sel_t              o_sel,
    input  logic [dbg_pkg::WORD_BITS-1:0]   i_rd_word,
    output logic [dbg_pkg::WORD_BITS-1:0]   o_word,
    output logic                            o_word_valid,
    input  logic                            i_word_ready
);
    import dbg_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_RUN,
        S_STEP,
        S_DUMP
    } state_e;

    state_e                   state;
    logic [IMEM_AW-1:0]       load_addr;
    logic [DUMP_CNT_BITS-1:0] dump_cnt;
    logic [DUMP_CNT_BITS-1:0] cnt_m2;
    logic                     loading;
    logic                     dump_drain;

    assign loading    = (state == S_IDLE) || (state == S_LOAD);
    // All words handed over, last bytes still leaving the serializer
    assign dump_drain = (state == S_DUMP) && (dump_cnt == DUMP_CNT_BITS'(DUMP_WORDS));

    // Reopen the input as soon as the serializer is empty again
    assign o_accept = loading || (dump_drain && i_word_ready);

    // First word of a load clears the core and lands on address 0
    assign o_clear     = (state == S_IDLE) &&
                         ((i_cmd.kind == LOAD_WORD) || (i_cmd.kind == LOAD_DONE));
    assign o_imem_we   = loading && (i_cmd.kind == LOAD_WORD);
    assign o_imem_addr = (state == S_IDLE) ? '0 : load_addr;
    assign o_imem_data = i_cmd.word;

    assign o_step_en = ((state == S_RUN) || (state == S_STEP)) && !i_halted;

    assign cnt_m2 = dump_cnt - DUMP_CNT_BITS'(2);

    // Dump order: PC, count, r0..r7, d0..d7
    always_comb begin
        o_sel.index = cnt_m2[SEL_IDX_BITS-1:0];
        if (dump_cnt < DUMP_CNT_BITS'(2)) begin
            o_sel.area  = AREA_CTRL;
            o_sel.index = dump_cnt[SEL_IDX_BITS-1:0];
        end else if (dump_cnt < DUMP_CNT_BITS'(2 + NUM_REGS)) begin
            o_sel.area = AREA_REG;
        end else begin
            o_sel.area = AREA_MEM;
        end
    end

    assign o_word       = i_rd_word;
    assign o_word_valid = (state == S_DUMP) && !dump_drain;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            load_addr <= '0;
            dump_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    case (i_cmd.kind)
                        RUN:  state <= S_RUN;
                        STEP: state <= S_STEP;
                        LOAD_WORD: begin
                            load_addr <= IMEM_AW'(1);
                            state     <= S_LOAD;
                        end
                        default: state <= S_IDLE;
                    endcase
                end
                S_LOAD: begin
                    if (i_cmd.kind == LOAD_WORD) begin
                        load_addr <= load_addr + 1'b1;
                    end else if (i_cmd.kind == LOAD_DONE) begin
                        state <= S_IDLE;
                    end
                end
                S_RUN: begin
                    if (i_halted) begin
                        state <= S_DUMP;
                    end
                end
                S_STEP: begin
                    state <= S_DUMP;  // Single enabled cycle
                end
                S_DUMP: begin
                    if (dump_drain) begin
                        if (i_word_ready) begin
                            dump_cnt <= '0;
                            state    <= S_IDLE;
                        end
                    end else if (i_word_ready) begin
                        dump_cnt <= dump_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/debug_top.sv ====
`timescale 1ns/1ps

module debug_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_rx_valid,
    input  logic [dbg_pkg::BYTE_BITS-1:0]   i_rx_data,
    output logic                            o_rx_ready,
    output logic                            o_tx_valid,
    output logic [dbg_pkg::BYTE_BITS-1:0]   o_tx_data,
    input  logic                            i_tx_ready
);
    import dbg_pkg::*;

    dbg_cmd_t             cmd;
    logic                 accept;
    logic                 step_en;
    logic                 clear;
    logic                 imem_we;
    logic [IMEM_AW-1:0]   imem_addr;
    logic [WORD_BITS-1:0] imem_data;
    logic                 halted;
    dump_sel_t            sel;
    logic [WORD_BITS-1:0] rd_word;
    logic [WORD_BITS-1:0] word;
    logic                 word_valid;
    logic                 word_ready;

    cmd_decoder cmd_decoder_inst (
        .clk        (clk),
        .reset      (reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .o_rx_ready (o_rx_ready),
        .i_accept   (accept),
        .o_cmd      (cmd)
    );

    debug_ctrl debug_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .i_cmd        (cmd),
        .o_accept     (accept),
        .o_step_en    (step_en),
        .o_clear      (clear),
        .o_imem_we    (imem_we),
        .o_imem_addr  (imem_addr),
        .o_imem_data  (imem_data),
        .i_halted     (halted),
        .o_sel        (sel),
        .i_rd_word    (rd_word),
        .o_word       (word),
        .o_word_valid (word_valid),
        .i_word_ready (word_ready)
    );

    tx_serializer tx_serializer_inst (
        .clk          (clk),
        .reset        (reset),
        .i_word       (word),
        .i_word_valid (word_valid),
        .o_word_ready (word_ready),
        .o_tx_valid   (o_tx_valid),
        .o_tx_data    (o_tx_data),
        .i_tx_ready   (i_tx_ready)
    );

    mini_core mini_core_inst (
        .clk         (clk),
        .reset       (reset),
        .i_step_en   (step_en),
        .i_clear     (clear),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_sel       (sel),
        .o_rd_word   (rd_word),
        .o_halted    (halted)
    );

endmodule

// ==== hw/mini_core.sv ====
`timescale 1ns/1ps

module mini_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_step_en,
    input  logic                            i_clear,
    input  logic                            i_imem_we,
    input  logic [dbg_pkg::IMEM_AW-1:0]     i_imem_addr,
    input  logic [dbg_pkg::WORD_BITS-1:0]   i_imem_data,
    input  dbg_pkg::dump_sel_t              i_sel,
    output logic [dbg_pkg::WORD_BITS-1:0]   o_rd_word,
    output logic                            o_halted
);
    import dbg_pkg::*;

    logic [WORD_BITS-1:0] imem [IMEM_WORDS];
    logic [WORD_BITS-1:0] regs [1:NUM_REGS-1];  // r0 is hardwired
    logic [WORD_BITS-1:0] dmem [DMEM_WORDS];

    logic [IMEM_AW-1:0]   pc;
    logic [WORD_BITS-1:0] cycle_cnt;
    logic                 halted;

    instr_u               instr;
    logic                 exec;
    logic                 is_add;
    logic                 is_addi;
    logic                 is_sw;
    logic                 is_halt;
    logic [WORD_BITS-1:0] rs_val;
    logic [WORD_BITS-1:0] rt_val;
    logic [WORD_BITS-1:0] imm_ext;
    logic [WORD_BITS-1:0] addr_sum;
    logic [REG_AW-1:0]    wr_idx;
    logic [WORD_BITS-1:0] wr_val;

    function automatic logic [WORD_BITS-1:0] rf_read(input logic [REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        return regs[idx];
    endfunction

    assign o_halted = halted;
    assign exec     = i_step_en && !halted;

    // Decode
    assign instr    = imem[pc];
    assign is_add   = (instr.r.opcode == OP_RTYPE) && (instr.r.funct == FN_ADD);
    assign is_addi  = (instr.i.opcode == OP_ADDI);
    assign is_sw    = (instr.i.opcode == OP_SW);
    assign is_halt  = (instr.i.opcode == OP_HALT);

    always_comb begin
        rs_val = rf_read(instr.r.rs[REG_AW-1:0]);
        rt_val = rf_read(instr.r.rt[REG_AW-1:0]);
    end

    assign imm_ext  = {{(WORD_BITS-16){instr.i.imm[15]}}, instr.i.imm};
    assign addr_sum = rs_val + imm_ext;

    assign wr_idx = is_add ? instr.r.rd[REG_AW-1:0] : instr.i.rt[REG_AW-1:0];
    assign wr_val = is_add ? (rs_val + rt_val) : addr_sum;

    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc        <= '0;
            cycle_cnt <= '0;
            halted    <= 1'b0;
        end else if (i_clear) begin
            pc        <= '0;
            cycle_cnt <= '0;
            halted    <= 1'b0;
        end else if (exec) begin
            cycle_cnt <= cycle_cnt + 1'b1;  // HALT cycle counts too
            if (is_halt) begin
                halted <= 1'b1;  // PC stays on HALT
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Register file and data memory
    always_ff @(posedge clk) begin
        if (i_clear) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            for (int j = 0; j < DMEM_WORDS; j++) begin
                dmem[j] <= '0;
            end
        end else if (exec) begin
            if ((is_add || is_addi) && (wr_idx != '0)) begin
                regs[wr_idx] <= wr_val;
            end
            if (is_sw) begin
                dmem[addr_sum[DMEM_AW-1:0]] <= rt_val;  // Address wraps mod 8
            end
        end
    end

    // Dump read port
    always_comb begin
        case (i_sel.area)
            AREA_CTRL: begin
                if (i_sel.index == SEL_COUNT) begin
                    o_rd_word = cycle_cnt;
                end else begin
                    o_rd_word = WORD_BITS'(pc);
                end
            end
            AREA_REG: o_rd_word = rf_read(i_sel.index[REG_AW-1:0]);
            AREA_MEM: o_rd_word = dmem[i_sel.index[DMEM_AW-1:0]];
            default:  o_rd_word = '0;
        endcase
    end

endmodule

// ==== hw/tx_serializer.sv ====
`timescale 1ns/1ps

module tx_serializer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [dbg_pkg::WORD_BITS-1:0]   i_word,
    input  logic                            i_word_valid,
    output logic                            o_word_ready,
    output logic                            o_tx_valid,
    output logic [dbg_pkg::BYTE_BITS-1:0]   o_tx_data,
    input  logic                            i_tx_ready
);
    import dbg_pkg::*;

    logic [WORD_BITS-1:0] shift_word;
    logic [2:0]           bytes_left;
    logic                 load;
    logic                 send;

    assign o_word_ready = (bytes_left == '0);  // Buffer empty
    assign o_tx_valid   = (bytes_left != '0);
    assign o_tx_data    = shift_word[WORD_BITS-1 -: BYTE_BITS];

    assign load = i_word_valid && o_word_ready;
    assign send = o_tx_valid && i_tx_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bytes_left <= '0;
        end else if (load) begin
            bytes_left <= 3'(BYTES_PER_WORD);
        end else if (send) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_word <= i_word;
        end else if (send) begin
            shift_word <= shift_word << BYTE_BITS;  // Next byte to the top
        end
    end

endmodule

// ==== vlog.f ====
hw/dbg_pkg.sv
hw/cmd_decoder.sv
hw/debug_ctrl.sv
hw/tx_serializer.sv
hw/mini_core.sv
hw/debug_top.sv
bench/debug_checker.sv
bench/tb_debug_top.sv
